// ==== dm_bus_pkg.sv ====
package dm_bus_pkg;

    // decoded part of the hart address
    localparam int DBG_ADDR_BITS = 12;

    localparam int PROG_BUF_SIZE = 10;
    localparam int DATA_COUNT    = 5;
    localparam int ABS_CMD_SIZE  = 10;

    // status writes from the hart
    localparam logic [DBG_ADDR_BITS-1:0] HALTED_ADDR    = 12'h100;
    localparam logic [DBG_ADDR_BITS-1:0] GOING_ADDR     = 12'h104;
    localparam logic [DBG_ADDR_BITS-1:0] RESUMING_ADDR  = 12'h108;
    localparam logic [DBG_ADDR_BITS-1:0] EXCEPTION_ADDR = 12'h10C;

    // regions read by the debug loop
    localparam logic [DBG_ADDR_BITS-1:0] WHERETO_ADDR      = 12'h300;
    localparam logic [DBG_ADDR_BITS-1:0] ABS_CMD_BASE_ADDR = 12'h310;
    localparam logic [DBG_ADDR_BITS-1:0] PROGBUF_BASE_ADDR = 12'h340;
    localparam logic [DBG_ADDR_BITS-1:0] DATA_BASE_ADDR    = 12'h380;
    localparam logic [DBG_ADDR_BITS-1:0] FLAGS_ADDR        = 12'h400;

    typedef logic [31:0] word_t;

    typedef struct packed {
        logic        req;
        logic        we;
        logic [31:0] addr;
        logic [3:0]  be;
        word_t       wdata;
    } hart_req_t;

    typedef struct packed {
        logic halted_wr;
        logic going_wr;
        logic resuming_wr;
        logic exception_wr;
    } bus_event_t;

    typedef enum logic [2:0] {
        RD_NONE,
        RD_WHERETO,
        RD_FLAGS,
        RD_DATA,
        RD_PROGBUF,
        RD_ABS_CMD
    } rd_sel_e;

    typedef struct packed {
        rd_sel_e    sel;
        logic [3:0] index;
    } rd_req_t;

    typedef word_t [PROG_BUF_SIZE-1:0] progbuf_t;
    typedef word_t [ABS_CMD_SIZE-1:0]  abs_prog_t;

endpackage

// ==== dm_cmd_pkg.sv ====
package dm_cmd_pkg;

    typedef enum logic [7:0] {
        CMD_ACCESS_REG   = 8'd0,
        CMD_QUICK_ACCESS = 8'd1,
        CMD_ACCESS_MEM   = 8'd2
    } cmd_type_e;

    typedef struct packed {
        cmd_type_e   cmd_type;
        logic        reserved;
        logic [2:0]  aarsize;
        logic        postincrement;
        logic        postexec;
        logic        transfer;
        logic        write;
        logic [15:0] regno;
    } dm_command_t;

    typedef enum logic [2:0] {
        CMDERR_NONE          = 3'd0,
        CMDERR_NOT_SUPPORTED = 3'd2,
        CMDERR_EXCEPTION     = 3'd3,
        CMDERR_HALT_RESUME   = 3'd4
    } cmderr_e;

    typedef enum logic [1:0] {
        CMD_IDLE,
        CMD_RESUME,
        CMD_GO,
        CMD_EXECUTING
    } cmd_state_e;

    localparam logic [4:0]  REG_S0        = 5'd8;
    localparam logic [4:0]  REG_A0        = 5'd10;
    localparam logic [11:0] CSR_DSCRATCH0 = 12'h7B2;
    localparam logic [11:0] CSR_DSCRATCH1 = 12'h7B3;

    localparam logic [31:0] INSTR_ILLEGAL = 32'h0000_0000;
    localparam logic [31:0] INSTR_NOP     = 32'h0000_0013;
    localparam logic [31:0] INSTR_EBREAK  = 32'h0010_0073;

    // J-type, imm[0] is implied zero
    function automatic logic [31:0] jal(logic [4:0] rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6F};
    endfunction

    // U-type, imm is the upper 20 bits
    function automatic logic [31:0] auipc(logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, 7'h17};
    endfunction

    function automatic logic [31:0] slli(logic [4:0] rd, logic [4:0] rs1, logic [4:0] shamt);
        return {7'b0, shamt, rs1, 3'h1, rd, 7'h13};
    endfunction

    function automatic logic [31:0] srli(logic [4:0] rd, logic [4:0] rs1, logic [4:0] shamt);
        return {7'b0, shamt, rs1, 3'h5, rd, 7'h13};
    endfunction

    function automatic logic [31:0] load(logic [2:0] size, logic [4:0] rd,
                                         logic [4:0] rs1, logic [11:0] offset);
        return {offset, rs1, size, rd, 7'h03};
    endfunction

    function automatic logic [31:0] store(logic [2:0] size, logic [4:0] rs2,
                                          logic [4:0] rs1, logic [11:0] offset);
        return {offset[11:5], rs2, rs1, size, offset[4:0], 7'h23};
    endfunction

    // csrrw x0, csr, rs1
    function automatic logic [31:0] csrw(logic [11:0] csr, logic [4:0] rs1);
        return {csr, rs1, 3'h1, 5'h0, 7'h73};
    endfunction

    // csrrs rd, csr, x0
    function automatic logic [31:0] csrr(logic [11:0] csr, logic [4:0] rd);
        return {csr, 5'h0, 3'h2, rd, 7'h73};
    endfunction

endpackage

// ==== dm_bus_decode.sv ====
`timescale 1ns/10ps

module dm_bus_decode (
    input  dm_bus_pkg::hart_req_t  hart_req_i,
    input  dm_bus_pkg::word_t      data_i,
    output dm_bus_pkg::bus_event_t bus_ev_o,
    output dm_bus_pkg::rd_req_t    rd_req_o,
    output dm_bus_pkg::word_t      data_o,
    output logic                   data_valid_o
);
    import dm_bus_pkg::*;

    logic [DBG_ADDR_BITS-1:0] addr;
    logic [DBG_ADDR_BITS-3:0] word_addr;
    logic [DBG_ADDR_BITS-3:0] data_off;
    logic [DBG_ADDR_BITS-3:0] prog_off;
    logic [DBG_ADDR_BITS-3:0] abs_off;
    logic                     wr;
    logic                     rd;

    assign addr      = hart_req_i.addr[DBG_ADDR_BITS-1:0];
    assign word_addr = addr[DBG_ADDR_BITS-1:2];
    assign wr        = hart_req_i.req & hart_req_i.we;
    assign rd        = hart_req_i.req & ~hart_req_i.we;

    // offsets wrap below the base, so one compare bounds each region
    assign data_off = word_addr - DATA_BASE_ADDR[DBG_ADDR_BITS-1:2];
    assign prog_off = word_addr - PROGBUF_BASE_ADDR[DBG_ADDR_BITS-1:2];
    assign abs_off  = word_addr - ABS_CMD_BASE_ADDR[DBG_ADDR_BITS-1:2];

    always_comb begin
        bus_ev_o                = '0;
        bus_ev_o.halted_wr      = wr && (addr == HALTED_ADDR);
        bus_ev_o.going_wr       = wr && (addr == GOING_ADDR);
        bus_ev_o.resuming_wr    = wr && (addr == RESUMING_ADDR);
        bus_ev_o.exception_wr   = wr && (addr == EXCEPTION_ADDR);
    end

    // byte merge toward the debugger
    always_comb begin
        data_o       = data_i;
        data_valid_o = 1'b0;
        if (wr && (data_off < DATA_COUNT)) begin
            data_valid_o = 1'b1;
            for (int b = 0; b < 4; b++) begin
                if (hart_req_i.be[b]) begin
                    data_o[8*b +: 8] = hart_req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        rd_req_o.sel   = RD_NONE;
        rd_req_o.index = '0;
        if (rd) begin
            if (addr == WHERETO_ADDR) begin
                rd_req_o.sel = RD_WHERETO;
            end else if (addr == FLAGS_ADDR) begin
                rd_req_o.sel = RD_FLAGS;
            end else if (data_off < DATA_COUNT) begin
                rd_req_o.sel   = RD_DATA;
                rd_req_o.index = data_off[3:0];
            end else if (prog_off < PROG_BUF_SIZE) begin
                rd_req_o.sel   = RD_PROGBUF;
                rd_req_o.index = prog_off[3:0];
            end else if (abs_off < ABS_CMD_SIZE) begin
                rd_req_o.sel   = RD_ABS_CMD;
                rd_req_o.index = abs_off[3:0];
            end
        end
    end

endmodule

// ==== dm_abstract_gen.sv ====
`timescale 1ns/10ps

module dm_abstract_gen (
    input  dm_cmd_pkg::dm_command_t cmd_i,
    output dm_bus_pkg::abs_prog_t   abs_prog_o,
    output logic                    unsupported_o
);
    import dm_bus_pkg::*;
    import dm_cmd_pkg::*;

    logic        is_gpr;
    logic        is_a0;
    logic [11:0] target_csr;

    // regno 0x1000..0x101f are the GPRs
    assign is_gpr = cmd_i.regno[12];
    assign is_a0  = is_gpr && (cmd_i.regno[4:0] == REG_A0);

    // a0 itself lives in dscratch1 while the program runs
    assign target_csr = is_a0 ? CSR_DSCRATCH1 : cmd_i.regno[11:0];

    assign unsupported_o = (cmd_i.cmd_type != CMD_ACCESS_REG) ||
                           (cmd_i.aarsize > 3'd2) ||
                           cmd_i.postincrement ||
                           (cmd_i.regno >= 16'h1020);

    always_comb begin
        abs_prog_o[0] = INSTR_ILLEGAL;
        // a0 <- page base of the debug memory
        abs_prog_o[1] = auipc(REG_A0, 20'd0);
        abs_prog_o[2] = srli(REG_A0, REG_A0, 5'd12);
        abs_prog_o[3] = slli(REG_A0, REG_A0, 5'd12);
        abs_prog_o[4] = INSTR_NOP;
        abs_prog_o[5] = INSTR_NOP;
        abs_prog_o[6] = INSTR_NOP;
        abs_prog_o[7] = INSTR_NOP;
        // restore a0
        abs_prog_o[8] = csrr(CSR_DSCRATCH1, REG_A0);
        abs_prog_o[9] = INSTR_EBREAK;

        if (unsupported_o) begin
            abs_prog_o[0] = INSTR_EBREAK;
        end else begin
            abs_prog_o[0] = csrw(CSR_DSCRATCH1, REG_A0);
            if (cmd_i.transfer) begin
                if (is_gpr && !is_a0) begin
                    // direct move between the gpr and data0
                    if (cmd_i.write) begin
                        abs_prog_o[4] = load(cmd_i.aarsize, cmd_i.regno[4:0], REG_A0,
                                             DATA_BASE_ADDR);
                    end else begin
                        abs_prog_o[4] = store(cmd_i.aarsize, cmd_i.regno[4:0], REG_A0,
                                              DATA_BASE_ADDR);
                    end
                end else begin
                    // s0 carries the value, saved around the move
                    abs_prog_o[4] = csrw(CSR_DSCRATCH0, REG_S0);
                    if (cmd_i.write) begin
                        abs_prog_o[5] = load(cmd_i.aarsize, REG_S0, REG_A0, DATA_BASE_ADDR);
                        abs_prog_o[6] = csrw(target_csr, REG_S0);
                    end else begin
                        abs_prog_o[5] = csrr(target_csr, REG_S0);
                        abs_prog_o[6] = store(cmd_i.aarsize, REG_S0, REG_A0, DATA_BASE_ADDR);
                    end
                    abs_prog_o[7] = csrr(CSR_DSCRATCH0, REG_S0);
                end
            end
            // fall through into the program buffer
            if (cmd_i.postexec) begin
                abs_prog_o[9] = INSTR_NOP;
            end
        end
    end

endmodule

// ==== dm_cmd_ctrl.sv ====
`timescale 1ns/10ps

module dm_cmd_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  dm_bus_pkg::bus_event_t bus_ev_i,
    input  logic                   haltreq_i,
    input  logic                   resumereq_i,
    input  logic                   ndmreset_i,
    input  logic                   clear_resumeack_i,
    input  logic                   cmd_valid_i,
    input  logic                   unsupported_i,
    output logic                   halted_o,
    output logic                   resumeack_o,
    output logic                   cmdbusy_o,
    output logic                   resume_flag_o,
    output logic                   go_flag_o,
    output logic                   cmderror_valid_o,
    output dm_cmd_pkg::cmderr_e    cmderror_o
);
    import dm_cmd_pkg::*;

    cmd_state_e state_q;
    cmd_state_e state_d;
    logic       halted_q;
    logic       resumeack_q;

    assign halted_o    = halted_q;
    assign resumeack_o = resumeack_q;

    always_comb begin
        state_d          = state_q;
        resume_flag_o    = 1'b0;
        go_flag_o        = 1'b0;
        cmdbusy_o        = (state_q != CMD_IDLE);
        cmderror_valid_o = 1'b0;
        cmderror_o       = CMDERR_NONE;

        case (state_q)
            CMD_IDLE: begin
                if (resumereq_i && halted_q && !resumeack_q && !haltreq_i) begin
                    state_d = CMD_RESUME;
                end
                if (cmd_valid_i) begin
                    if (!halted_q) begin
                        cmderror_valid_o = 1'b1;
                        cmderror_o       = CMDERR_HALT_RESUME;
                    end else if (unsupported_i) begin
                        cmderror_valid_o = 1'b1;
                        cmderror_o       = CMDERR_NOT_SUPPORTED;
                    end else begin
                        state_d = CMD_GO;
                    end
                end
            end
            CMD_RESUME: begin
                resume_flag_o = 1'b1;
                if (resumeack_q) begin
                    state_d = CMD_IDLE;
                end
            end
            CMD_GO: begin
                go_flag_o = 1'b1;
                if (bus_ev_i.going_wr) begin
                    state_d = CMD_EXECUTING;
                end
            end
            CMD_EXECUTING: begin
                // hart is back in the park loop
                if (bus_ev_i.halted_wr) begin
                    state_d = CMD_IDLE;
                end
            end
            default: begin
                state_d = CMD_IDLE;
            end
        endcase

        if (bus_ev_i.exception_wr) begin
            cmderror_valid_o = 1'b1;
            cmderror_o       = CMDERR_EXCEPTION;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= CMD_IDLE;
            halted_q    <= 1'b0;
            resumeack_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // hart writes win over the debugger side clears
            if (bus_ev_i.halted_wr) begin
                halted_q <= 1'b1;
            end else if (bus_ev_i.resuming_wr || (ndmreset_i && !haltreq_i)) begin
                halted_q <= 1'b0;
            end
            if (bus_ev_i.resuming_wr) begin
                resumeack_q <= 1'b1;
            end else if (clear_resumeack_i) begin
                resumeack_q <= 1'b0;
            end
        end
    end

endmodule

// ==== dm_read_port.sv ====
`timescale 1ns/10ps

module dm_read_port (
    input  logic                    clk,
    input  logic                    rst_n,
    input  dm_bus_pkg::rd_req_t     rd_req_i,
    input  dm_cmd_pkg::dm_command_t cmd_i,
    input  logic                    cmdbusy_i,
    input  logic                    resume_flag_i,
    input  logic                    go_flag_i,
    input  dm_bus_pkg::progbuf_t    progbuf_i,
    input  dm_bus_pkg::abs_prog_t   abs_prog_i,
    input  dm_bus_pkg::word_t       data_i,
    output dm_bus_pkg::word_t       rdata_o
);
    import dm_bus_pkg::*;
    import dm_cmd_pkg::*;

    word_t rdata_q;
    word_t rdata_d;

    assign rdata_o = rdata_q;

    always_comb begin
        rdata_d = rdata_q;
        case (rd_req_i.sel)
            RD_WHERETO: begin
                // jal x0, relative to whereto itself
                if (cmdbusy_i && (cmd_i.cmd_type == CMD_ACCESS_REG)) begin
                    if (cmd_i.postexec) begin
                        rdata_d = jal(5'd0, 21'(PROGBUF_BASE_ADDR - WHERETO_ADDR));
                    end else begin
                        rdata_d = jal(5'd0, 21'(ABS_CMD_BASE_ADDR - WHERETO_ADDR));
                    end
                end
            end
            RD_FLAGS: begin
                rdata_d = {30'b0, resume_flag_i, go_flag_i};
            end
            RD_DATA: begin
                rdata_d = data_i;
            end
            RD_PROGBUF: begin
                rdata_d = progbuf_i[rd_req_i.index];
            end
            RD_ABS_CMD: begin
                rdata_d = abs_prog_i[rd_req_i.index];
            end
            default: begin
                rdata_d = rdata_q;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_q <= '0;
        end else begin
            rdata_q <= rdata_d;
        end
    end

endmodule

// ==== dm_mem.sv ====
`timescale 1ns/10ps

module dm_mem (
    input  logic                    clk,
    input  logic                    rst_n,
    input  dm_bus_pkg::hart_req_t   hart_req_i,
    output dm_bus_pkg::word_t       rdata_o,
    input  logic                    haltreq_i,
    input  logic                    resumereq_i,
    input  logic                    ndmreset_i,
    input  logic                    clear_resumeack_i,
    input  logic                    cmd_valid_i,
    input  dm_cmd_pkg::dm_command_t cmd_i,
    input  dm_bus_pkg::progbuf_t    progbuf_i,
    input  dm_bus_pkg::word_t       data_i,
    output logic                    halted_o,
    output logic                    resumeack_o,
    output logic                    cmdbusy_o,
    output logic                    cmderror_valid_o,
    output dm_cmd_pkg::cmderr_e     cmderror_o,
    output dm_bus_pkg::word_t       data_o,
    output logic                    data_valid_o
);
    import dm_bus_pkg::*;

    bus_event_t bus_ev;
    rd_req_t    rd_req;
    abs_prog_t  abs_prog;
    logic       unsupported;
    logic       resume_flag;
    logic       go_flag;

    // hart bus in
    dm_bus_decode u_bus_decode (
        .hart_req_i   (hart_req_i),
        .data_i       (data_i),
        .bus_ev_o     (bus_ev),
        .rd_req_o     (rd_req),
        .data_o       (data_o),
        .data_valid_o (data_valid_o)
    );

    dm_abstract_gen u_abstract_gen (
        .cmd_i         (cmd_i),
        .abs_prog_o    (abs_prog),
        .unsupported_o (unsupported)
    );

    dm_cmd_ctrl u_cmd_ctrl (
        .clk               (clk),
        .rst_n             (rst_n),
        .bus_ev_i          (bus_ev),
        .haltreq_i         (haltreq_i),
        .resumereq_i       (resumereq_i),
        .ndmreset_i        (ndmreset_i),
        .clear_resumeack_i (clear_resumeack_i),
        .cmd_valid_i       (cmd_valid_i),
        .unsupported_i     (unsupported),
        .halted_o          (halted_o),
        .resumeack_o       (resumeack_o),
        .cmdbusy_o         (cmdbusy_o),
        .resume_flag_o     (resume_flag),
        .go_flag_o         (go_flag),
        .cmderror_valid_o  (cmderror_valid_o),
        .cmderror_o        (cmderror_o)
    );

    // registered read word back to the hart
    dm_read_port u_read_port (
        .clk           (clk),
        .rst_n         (rst_n),
        .rd_req_i      (rd_req),
        .cmd_i         (cmd_i),
        .cmdbusy_i     (cmdbusy_o),
        .resume_flag_i (resume_flag),
        .go_flag_i     (go_flag),
        .progbuf_i     (progbuf_i),
        .abs_prog_i    (abs_prog),
        .data_i        (data_i),
        .rdata_o       (rdata_o)
    );

endmodule

// ==== tb_dm_mem.sv ====
`timescale 1ns/10ps

module tb_dm_mem;
    import dm_bus_pkg::*;
    import dm_cmd_pkg::*;

    // five short tests, each well under 100 cycles, plus reset
    localparam int CYCLE_LIMIT = 2000;

    logic        clk;
    logic        rst_n;
    hart_req_t   hart_req;
    word_t       rdata;
    logic        haltreq;
    logic        resumereq;
    logic        ndmreset;
    logic        clear_resumeack;
    logic        cmd_valid;
    dm_command_t cmd;
    progbuf_t    progbuf;
    word_t       data_in;
    logic        halted;
    logic        resumeack;
    logic        cmdbusy;
    logic        cmderror_valid;
    cmderr_e     cmderror;
    word_t       data_out;
    logic        data_valid;

    string test_name;
    int    test_errors;
    int    tests_passed;
    int    tests_failed;
    int    cycle_count;

    dm_mem uut (
        .clk               (clk),
        .rst_n             (rst_n),
        .hart_req_i        (hart_req),
        .rdata_o           (rdata),
        .haltreq_i         (haltreq),
        .resumereq_i       (resumereq),
        .ndmreset_i        (ndmreset),
        .clear_resumeack_i (clear_resumeack),
        .cmd_valid_i       (cmd_valid),
        .cmd_i             (cmd),
        .progbuf_i         (progbuf),
        .data_i            (data_in),
        .halted_o          (halted),
        .resumeack_o       (resumeack),
        .cmdbusy_o         (cmdbusy),
        .cmderror_valid_o  (cmderror_valid),
        .cmderror_o        (cmderror),
        .data_o            (data_out),
        .data_valid_o      (data_valid)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("FAILED %s expected %h actual %h (%s)", test_name, exp, act, what);
            test_errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            $display("FAILED %s expected %b actual %b (%s)", test_name, exp, act, what);
            test_errors++;
        end
    endtask

    task automatic check_err(input string what, input cmderr_e exp, input cmderr_e act);
        if (exp !== act) begin
            $display("FAILED %s expected %0d actual %0d (%s)", test_name, exp, act, what);
            test_errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            $display("test %s: ok", test_name);
            tests_passed++;
        end else begin
            $display("test %s: %0d errors", test_name, test_errors);
            tests_failed++;
        end
    endtask

    // all drives happen 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic start_write(input logic [31:0] addr, input word_t wdata, input logic [3:0] be);
        hart_req.req   = 1'b1;
        hart_req.we    = 1'b1;
        hart_req.addr  = addr;
        hart_req.be    = be;
        hart_req.wdata = wdata;
    endtask

    task automatic end_access();
        next_cycle();
        hart_req = '0;
    endtask

    task automatic bus_write(input logic [31:0] addr, input word_t wdata);
        start_write(addr, wdata, 4'hF);
        end_access();
    endtask

    task automatic bus_read(input logic [31:0] addr, output word_t value);
        hart_req.req  = 1'b1;
        hart_req.we   = 1'b0;
        hart_req.addr = addr;
        hart_req.be   = 4'hF;
        end_access();
        value = rdata;
    endtask

    task automatic send_cmd(input dm_command_t c, input logic exp_valid, input cmderr_e exp_err);
        cmd       = c;
        cmd_valid = 1'b1;
        #1;
        check_bit("cmderror_valid", exp_valid, cmderror_valid);
        check_err("cmderror", exp_err, cmderror);
        next_cycle();
        cmd_valid = 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (cmdbusy && n < 20) begin
            next_cycle();
            n++;
        end
        if (cmdbusy) begin
            $display("%s: command still busy after 20 cycles", test_name);
            test_errors++;
        end
    endtask

    function automatic dm_command_t make_cmd(input cmd_type_e t, input logic [2:0] size,
                                             input logic postexec, input logic write,
                                             input logic [15:0] regno);
        dm_command_t c;
        c               = '0;
        c.cmd_type      = t;
        c.aarsize       = size;
        c.postexec      = postexec;
        c.transfer      = 1'b1;
        c.write         = write;
        c.regno         = regno;
        return c;
    endfunction

    task automatic status_test();
        word_t value;
        begin_test("status");
        check_word("rdata after reset", 32'h0, rdata);
        bus_write(32'h100, 32'h0);
        check_bit("halted set", 1'b1, halted);
        resumereq = 1'b1;
        next_cycle();
        resumereq = 1'b0;
        bus_read(32'h400, value);
        check_word("resume flag", 32'h2, value);
        bus_write(32'h108, 32'h0);
        check_bit("halted cleared by resuming", 1'b0, halted);
        check_bit("resumeack set", 1'b1, resumeack);
        clear_resumeack = 1'b1;
        next_cycle();
        clear_resumeack = 1'b0;
        check_bit("resumeack cleared", 1'b0, resumeack);
        bus_write(32'h100, 32'h0);
        ndmreset = 1'b1;
        next_cycle();
        ndmreset = 1'b0;
        check_bit("halted cleared by ndmreset", 1'b0, halted);
        end_test();
    endtask

    task automatic cmd_error_test();
        begin_test("cmd_errors");
        send_cmd(make_cmd(CMD_ACCESS_REG, 3'd2, 1'b0, 1'b0, 16'h1005), 1'b1, CMDERR_HALT_RESUME);
        check_bit("busy while running", 1'b0, cmdbusy);
        bus_write(32'h100, 32'h0);
        send_cmd(make_cmd(CMD_ACCESS_MEM, 3'd2, 1'b0, 1'b0, 16'h1005), 1'b1,
                 CMDERR_NOT_SUPPORTED);
        check_bit("busy after access mem", 1'b0, cmdbusy);
        send_cmd(make_cmd(CMD_ACCESS_REG, 3'd3, 1'b0, 1'b0, 16'h1005), 1'b1,
                 CMDERR_NOT_SUPPORTED);
        check_bit("busy after aarsize 3", 1'b0, cmdbusy);
        start_write(32'h10C, 32'h0, 4'hF);
        #1;
        check_bit("exception valid", 1'b1, cmderror_valid);
        check_err("exception code", CMDERR_EXCEPTION, cmderror);
        end_access();
        end_test();
    endtask

    task automatic gpr_write_test();
        word_t value;
        word_t exp_prog [10];
        begin_test("gpr_write");
        // x5 <- data0, lw through a0 at offset 0x380
        exp_prog = '{32'h7B35_1073, 32'h0000_0517, 32'h00C5_5513, 32'h00C5_1513,
                     32'h3805_2283, 32'h0000_0013, 32'h0000_0013, 32'h0000_0013,
                     32'h7B30_2573, 32'h0010_0073};
        bus_write(32'h100, 32'h0);
        send_cmd(make_cmd(CMD_ACCESS_REG, 3'd2, 1'b0, 1'b1, 16'h1005), 1'b0, CMDERR_NONE);
        check_bit("busy after command", 1'b1, cmdbusy);
        bus_read(32'h400, value);
        check_word("go flag", 32'h1, value);
        bus_read(32'h300, value);
        check_word("whereto", 32'h0100_006F, value);
        for (int i = 0; i < 10; i++) begin
            bus_read(32'h310 + 4 * i, value);
            check_word($sformatf("abstract word %0d", i), exp_prog[i], value);
        end
        bus_write(32'h104, 32'h0);
        check_bit("busy after going", 1'b1, cmdbusy);
        bus_write(32'h100, 32'h0);
        wait_idle();
        check_bit("busy after halted", 1'b0, cmdbusy);
        end_test();
    endtask

    task automatic csr_read_test();
        word_t value;
        word_t exp_prog [10];
        begin_test("csr_read_postexec");
        // s0 saved in dscratch0 around csrr of mepc and sw to data0
        exp_prog = '{32'h7B35_1073, 32'h0000_0517, 32'h00C5_5513, 32'h00C5_1513,
                     32'h7B24_1073, 32'h3410_2473, 32'h3885_2023, 32'h7B20_2473,
                     32'h7B30_2573, 32'h0000_0013};
        send_cmd(make_cmd(CMD_ACCESS_REG, 3'd2, 1'b1, 1'b0, 16'h0341), 1'b0, CMDERR_NONE);
        check_bit("busy after command", 1'b1, cmdbusy);
        bus_read(32'h300, value);
        check_word("whereto", 32'h0400_006F, value);
        for (int i = 0; i < 10; i++) begin
            bus_read(32'h310 + 4 * i, value);
            check_word($sformatf("abstract word %0d", i), exp_prog[i], value);
        end
        bus_write(32'h104, 32'h0);
        bus_write(32'h100, 32'h0);
        wait_idle();
        end_test();
    endtask

    task automatic data_progbuf_test();
        word_t value;
        word_t wval;
        word_t exp;
        begin_test("data_progbuf");
        wval = $urandom;
        start_write(32'h388, wval, 4'b0101);
        #1;
        exp = {data_in[31:24], wval[23:16], data_in[15:8], wval[7:0]};
        check_bit("data_valid", 1'b1, data_valid);
        check_word("merged data", exp, data_out);
        next_cycle();
        // same write with req low does not count
        hart_req.req = 1'b0;
        #1;
        check_bit("data_valid without req", 1'b0, data_valid);
        end_access();
        data_in = $urandom;
        bus_read(32'h384, value);
        check_word("data read", data_in, value);
        for (int i = 0; i < 10; i++) begin
            bus_read(32'h340 + 4 * i, value);
            check_word($sformatf("progbuf word %0d", i), progbuf[i], value);
        end
        end_test();
    endtask

    initial begin
        void'($urandom(95));
        clk             = 1'b0;
        rst_n           = 1'b0;
        hart_req        = '0;
        haltreq         = 1'b0;
        resumereq       = 1'b0;
        ndmreset        = 1'b0;
        clear_resumeack = 1'b0;
        cmd_valid       = 1'b0;
        cmd             = '0;
        data_in         = $urandom;
        for (int i = 0; i < PROG_BUF_SIZE; i++) begin
            progbuf[i] = $urandom;
        end
        cycle_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        status_test();
        cmd_error_test();
        gpr_write_test();
        csr_read_test();
        data_progbuf_test();

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== list.f ====
dm_bus_pkg.sv
dm_cmd_pkg.sv
dm_bus_decode.sv
dm_abstract_gen.sv
dm_cmd_ctrl.sv
dm_read_port.sv
dm_mem.sv
tb_dm_mem.sv

// ==== Bender.yml ====
package:
  name: dm_mem

sources:
  - dm_bus_pkg.sv
  - dm_cmd_pkg.sv
  - dm_bus_decode.sv
  - dm_abstract_gen.sv
  - dm_cmd_ctrl.sv
  - dm_read_port.sv
  - dm_mem.sv
  - target: test
    files:
      - tb_dm_mem.sv
